//--- include/ntt_ctrl_defines.svh
`ifndef NTT_CTRL_DEFINES_SVH
`define NTT_CTRL_DEFINES_SVH

// coefficient load interval in cycles
`define NTT_DEGREE 32

`define CNT_W 8

// butterfly reads per iteration
`define BU_PER_ITER 16
`define BU_PER_ITER_LAST 8

// group lengths for iterations 1 and 2
`define GROUP_LEN_1 1
`define GROUP_LEN_2 8

// pipeline drain after each iteration
`define DRAIN_0 12
`define DRAIN_1 12
`define DRAIN_2 12
`define DRAIN_3 2

// twiddle depth
`define LAST_DEPTH 5
`define DEPTH_W 4

`endif

//--- hdl/ntt_ctrl_pkg.sv
`include "ntt_ctrl_defines.svh"

package ntt_ctrl_pkg;

    // controller phase
    typedef enum logic [2:0] {
        RESET,
        LOAD,
        ITER,
        DRAIN,
        DONE
    } ctrl_phase_e;

    // twiddle factor generator controls
    typedef struct packed {
        logic                init_base;
        logic                init_const;
        logic                ren;
        logic                wen;
        logic [`DEPTH_W-1:0] depth;
    } tf_ctrl_t;

    // coefficient memory controls
    typedef struct packed {
        logic r_enable;
        logic w_enable;
        logic last_stage;
    } mem_ctrl_t;

    // address generator enables
    typedef struct packed {
        logic enable;
        logic enable_k2;
    } agu_ctrl_t;

endpackage

//--- hdl/load_timer.sv
`include "ntt_ctrl_defines.svh"

module load_timer (
    input  logic clk,
    input  logic rst,
    output logic load_done
);

    logic [`CNT_W-1:0] load_cnt;

    // counts up to NTT_DEGREE, then parks
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_cnt  <= '0;
            load_done <= 1'b0;
        end else begin
            if (load_cnt == `CNT_W'(`NTT_DEGREE)) begin
                load_done <= 1'b1;
            end else begin
                load_cnt <= load_cnt + 1'b1;
            end
        end
    end

    // sticky once set
    load_done_sticky: assert property (
        @(posedge clk) disable iff (rst)
        load_done |=> load_done
    );

endmodule

//--- hdl/iter_sequencer.sv
`include "ntt_ctrl_defines.svh"

module iter_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_done,
    input  logic                      last_read,
    output ntt_ctrl_pkg::ctrl_phase_e phase,
    output logic [1:0]                iter
);

    import ntt_ctrl_pkg::*;

    logic [`CNT_W-1:0] drain_cnt;
    logic [`CNT_W-1:0] drain_len;

    // drain length of the current iteration
    always_comb begin
        case (iter)
            2'd0: begin
                drain_len = `CNT_W'(`DRAIN_0);
            end
            2'd1: begin
                drain_len = `CNT_W'(`DRAIN_1);
            end
            2'd2: begin
                drain_len = `CNT_W'(`DRAIN_2);
            end
            default: begin
                drain_len = `CNT_W'(`DRAIN_3);
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= RESET;
            iter      <= 2'd0;
            drain_cnt <= '0;
        end else begin
            case (phase)
                RESET: begin
                    phase <= LOAD;
                end
                LOAD: begin
                    if (load_done) begin
                        phase <= ITER;
                        iter  <= 2'd0;
                    end
                end
                ITER: begin
                    // last read seen, start the drain
                    if (last_read) begin
                        phase     <= DRAIN;
                        drain_cnt <= drain_len - 1'b1;
                    end
                end
                DRAIN: begin
                    if (drain_cnt == '0) begin
                        if (iter == 2'd3) begin
                            phase <= DONE;
                        end else begin
                            phase <= ITER;
                            iter  <= iter + 2'd1;
                        end
                    end else begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                DONE: begin
                    phase <= DONE;
                end
                default: begin
                    phase <= RESET;
                end
            endcase
        end
    end

    // last iteration is terminal
    iter_no_wrap: assert property (
        @(posedge clk) disable iff (rst)
        (iter == 2'd3) |=> (iter == 2'd3)
    );

endmodule

//--- hdl/butterfly_counter.sv
`include "ntt_ctrl_defines.svh"

module butterfly_counter (
    input  logic                      clk,
    input  logic                      rst,
    input  ntt_ctrl_pkg::ctrl_phase_e phase,
    input  logic [1:0]                iter,
    input  logic                      rd_fire,
    output logic                      last_read,
    output logic                      wb_window
);

    import ntt_ctrl_pkg::*;

    logic [`CNT_W-1:0] rd_cnt;
    logic [`CNT_W-1:0] grp_pos;
    logic [`CNT_W-1:0] grp_idx;
    logic [`CNT_W-1:0] rd_target;
    logic [`CNT_W-1:0] grp_len;
    logic              grp_end;

    // iteration 3 has the short read count
    assign rd_target = (iter == 2'd3) ? `CNT_W'(`BU_PER_ITER_LAST) : `CNT_W'(`BU_PER_ITER);
    assign grp_len   = (iter == 2'd2) ? `CNT_W'(`GROUP_LEN_2) : `CNT_W'(`GROUP_LEN_1);
    assign grp_end   = (grp_pos == grp_len - 1'b1);

    assign last_read = rd_fire && (rd_cnt == rd_target - 1'b1);

    // twiddle write-back window per iteration
    always_comb begin
        case (iter)
            2'd1: begin
                wb_window = grp_end &&
                    (grp_idx != `CNT_W'(`BU_PER_ITER / `GROUP_LEN_1 - 1));
            end
            2'd2: begin
                wb_window = (grp_idx == `CNT_W'(1));
            end
            2'd3: begin
                wb_window = (rd_cnt >= `CNT_W'(2));
            end
            default: begin
                wb_window = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_cnt  <= '0;
            grp_pos <= '0;
            grp_idx <= '0;
        end else begin
            if (phase == DRAIN) begin
                rd_cnt  <= '0;
                grp_pos <= '0;
                grp_idx <= '0;
            end else if (rd_fire) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (grp_end) begin
                    grp_pos <= '0;
                    grp_idx <= grp_idx + 1'b1;
                end else begin
                    grp_pos <= grp_pos + 1'b1;
                end
            end
        end
    end

    // reads only while iterating
    rd_in_iter: assert property (
        @(posedge clk) disable iff (rst)
        rd_fire |-> (phase == ITER)
    );

endmodule

//--- hdl/ctrl_decode.sv
`include "ntt_ctrl_defines.svh"

module ctrl_decode (
    input  ntt_ctrl_pkg::ctrl_phase_e phase,
    input  logic [1:0]                iter,
    input  logic                      bn_ma_out_en,
    input  logic                      r_enable_out,
    input  logic                      ntt_done,
    input  logic                      wb_window,
    output logic                      rd_fire,
    output ntt_ctrl_pkg::tf_ctrl_t    tf,
    output ntt_ctrl_pkg::mem_ctrl_t   mem,
    output ntt_ctrl_pkg::agu_ctrl_t   agu,
    output logic                      ntt_enable,
    output logic                      done
);

    import ntt_ctrl_pkg::*;

    logic last_iter;

    assign last_iter = (iter == 2'd3);

    always_comb begin
        rd_fire    = 1'b0;
        tf         = '0;
        mem        = '0;
        agu        = '0;
        ntt_enable = 1'b0;
        done       = 1'b0;
        case (phase)
            LOAD: begin
                // twiddle generator init during coefficient load
                tf.init_base  = 1'b1;
                tf.init_const = 1'b1;
            end
            ITER: begin
                rd_fire      = bn_ma_out_en;
                tf.ren       = rd_fire;
                tf.wen       = rd_fire && wb_window;
                mem.r_enable = rd_fire;
                if (rd_fire) begin
                    if (last_iter) begin
                        tf.depth = `DEPTH_W'(`LAST_DEPTH);
                    end else begin
                        tf.depth = `DEPTH_W'(iter);
                    end
                end
                mem.w_enable   = ntt_done;
                mem.last_stage = last_iter;
                ntt_enable     = r_enable_out;
                agu.enable     = !last_iter;
                agu.enable_k2  = last_iter;
            end
            DRAIN: begin
                // flush results still in the butterfly pipe
                mem.w_enable   = 1'b1;
                mem.last_stage = last_iter;
                ntt_enable     = r_enable_out;
            end
            DONE: begin
                done = 1'b1;
            end
            default: begin
                done = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/ntt_ctrl_top.sv
`include "ntt_ctrl_defines.svh"

module ntt_ctrl_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    bn_ma_out_en,
    input  logic                    r_enable_out,
    input  logic                    ntt_done,
    output ntt_ctrl_pkg::tf_ctrl_t  tf,
    output ntt_ctrl_pkg::mem_ctrl_t mem,
    output ntt_ctrl_pkg::agu_ctrl_t agu,
    output logic                    ntt_enable,
    output logic                    done
);

    logic                      load_done;
    ntt_ctrl_pkg::ctrl_phase_e phase;
    logic [1:0]                iter;
    logic                      rd_fire;
    logic                      last_read;
    logic                      wb_window;

    load_timer i_load_timer (
        .clk       (clk),
        .rst       (rst),
        .load_done (load_done)
    );

    iter_sequencer i_iter_sequencer (
        .clk       (clk),
        .rst       (rst),
        .load_done (load_done),
        .last_read (last_read),
        .phase     (phase),
        .iter      (iter)
    );

    butterfly_counter i_butterfly_counter (
        .clk       (clk),
        .rst       (rst),
        .phase     (phase),
        .iter      (iter),
        .rd_fire   (rd_fire),
        .last_read (last_read),
        .wb_window (wb_window)
    );

    ctrl_decode i_ctrl_decode (
        .phase        (phase),
        .iter         (iter),
        .bn_ma_out_en (bn_ma_out_en),
        .r_enable_out (r_enable_out),
        .ntt_done     (ntt_done),
        .wb_window    (wb_window),
        .rd_fire      (rd_fire),
        .tf           (tf),
        .mem          (mem),
        .agu          (agu),
        .ntt_enable   (ntt_enable),
        .done         (done)
    );

endmodule

//--- dv/ntt_ctrl_tb.sv
`include "ntt_ctrl_defines.svh"

module ntt_ctrl_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import ntt_ctrl_pkg::*;

    // expected behavior of one butterfly iteration
    typedef struct packed {
        int reads;
        int wbs;
        int depth;
        int drain;
    } iter_row_t;

    localparam int WAIT_TIMEOUT = 100;
    localparam int ITER_TIMEOUT = 400;

    logic      clk;
    logic      rst;
    logic      bn_ma_out_en;
    logic      r_enable_out;
    logic      ntt_done;
    tf_ctrl_t  tf;
    mem_ctrl_t mem;
    agu_ctrl_t agu;
    logic      ntt_enable;
    logic      done;

    iter_row_t rows [4];
    integer    seed;
    // first iteration cycle already sampled by the load watcher
    logic      cycle_ready;

    ntt_ctrl_top i_ntt_ctrl_top (
        .clk          (clk),
        .rst          (rst),
        .bn_ma_out_en (bn_ma_out_en),
        .r_enable_out (r_enable_out),
        .ntt_done     (ntt_done),
        .tf           (tf),
        .mem          (mem),
        .agu          (agu),
        .ntt_enable   (ntt_enable),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic abort_wait(input string what);
        $display("timeout while waiting for %s", what);
        $display("Done: errors found");
        $fatal(1, "wait loop timed out");
    endtask

    // drive 1 ns after the edge, sample on the falling edge
    task automatic next_cycle(input logic force_en);
        logic [31:0] rnd;
        @(posedge clk);
        #1;
        rnd = $random(seed);
        bn_ma_out_en = force_en ? 1'b1 : (rnd[1:0] != 2'b00);
        rnd = $random(seed);
        r_enable_out = rnd[0];
        rnd = $random(seed);
        ntt_done = rnd[0];
        @(negedge clk);
    endtask

    task automatic expect_idle(input string where);
        check_value({where, " tf"}, 32'(tf), 32'd0);
        check_value({where, " mem"}, 32'(mem), 32'd0);
        check_value({where, " agu"}, 32'(agu), 32'd0);
        check_value({where, " ntt_enable"}, 32'(ntt_enable), 32'd0);
        check_value({where, " done"}, 32'(done), 32'd0);
    endtask

    task automatic apply_reset();
        repeat (8) begin
            next_cycle(1'b0);
            expect_idle("in reset");
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        expect_idle("after reset");
    endtask

    task automatic watch_load();
        int load_cycles;
        load_cycles = 0;
        next_cycle(1'b0);
        check_value("tf.init_base at load start", 32'(tf.init_base), 32'd1);
        while (tf.init_base) begin
            load_cycles++;
            if (load_cycles > WAIT_TIMEOUT) begin
                abort_wait("the end of the coefficient load");
            end
            check_value("tf.init_const", 32'(tf.init_const), 32'd1);
            check_value("tf.ren in load", 32'(tf.ren), 32'd0);
            check_value("mem in load", 32'(mem), 32'd0);
            check_value("agu in load", 32'(agu), 32'd0);
            check_value("done in load", 32'(done), 32'd0);
            next_cycle(1'b0);
        end
        // load lasts until one cycle after load_done
        check_value("load interval", 32'(load_cycles), 32'(`NTT_DEGREE + 1));
        cycle_ready = 1'b1;
    endtask

    task automatic run_iteration(input int idx);
        iter_row_t row;
        int        reads;
        int        wbs;
        int        cycles;
        logic      last;
        row = rows[idx];
        reads = 0;
        wbs = 0;
        cycles = 0;
        last = (idx == 3);
        while (reads < row.reads) begin
            if (!cycle_ready) begin
                next_cycle(1'b0);
            end
            cycle_ready = 1'b0;
            cycles++;
            if (cycles > ITER_TIMEOUT) begin
                abort_wait("the reads of an iteration");
            end
            check_value("tf.ren", 32'(tf.ren), 32'(bn_ma_out_en));
            check_value("mem.r_enable", 32'(mem.r_enable), 32'(bn_ma_out_en));
            check_value("mem.w_enable", 32'(mem.w_enable), 32'(ntt_done));
            check_value("ntt_enable", 32'(ntt_enable), 32'(r_enable_out));
            check_value("mem.last_stage", 32'(mem.last_stage), 32'(last));
            check_value("agu.enable", 32'(agu.enable), 32'(!last));
            check_value("agu.enable_k2", 32'(agu.enable_k2), 32'(last));
            check_value("tf.init_base", 32'(tf.init_base), 32'd0);
            check_value("tf.init_const", 32'(tf.init_const), 32'd0);
            check_value("done", 32'(done), 32'd0);
            if (tf.ren) begin
                check_value("tf.depth", 32'(tf.depth), row.depth);
                reads++;
            end else begin
                check_value("tf.wen without tf.ren", 32'(tf.wen), 32'd0);
                check_value("tf.depth without read", 32'(tf.depth), 32'd0);
            end
            if (tf.wen) begin
                wbs++;
            end
        end
        check_value("tf.wen pulses", 32'(wbs), row.wbs);
    endtask

    // operands offered all through the drain, none may be read
    task automatic run_drain(input int idx);
        logic last;
        last = (idx == 3);
        for (int n = 0; n < rows[idx].drain; n++) begin
            next_cycle(1'b1);
            check_value("tf in drain", 32'(tf), 32'd0);
            check_value("mem.w_enable in drain", 32'(mem.w_enable), 32'd1);
            check_value("ntt_enable in drain", 32'(ntt_enable), 32'(r_enable_out));
            check_value("mem.last_stage in drain", 32'(mem.last_stage), 32'(last));
            check_value("agu in drain", 32'(agu), 32'd0);
            check_value("done in drain", 32'(done), 32'd0);
        end
    endtask

    task automatic watch_done();
        int wait_cnt;
        wait_cnt = 0;
        next_cycle(1'b1);
        while (!done) begin
            wait_cnt++;
            if (wait_cnt > WAIT_TIMEOUT) begin
                abort_wait("done after the last drain");
            end
            check_value("tf.ren before done", 32'(tf.ren), 32'd0);
            next_cycle(1'b1);
        end
        // done follows the last drain cycle directly
        check_value("cycles from last drain to done", 32'(wait_cnt), 32'd0);
        repeat (20) begin
            next_cycle(1'b1);
            check_value("done held", 32'(done), 32'd1);
            check_value("tf after done", 32'(tf), 32'd0);
            check_value("mem after done", 32'(mem), 32'd0);
            check_value("agu after done", 32'(agu), 32'd0);
            check_value("ntt_enable after done", 32'(ntt_enable), 32'd0);
        end
    endtask

    initial begin
        seed = 32'hcc78_3e79;
        cycle_ready = 1'b0;
        rst = 1'b1;
        bn_ma_out_en = 1'b0;
        r_enable_out = 1'b0;
        ntt_done = 1'b0;
        rows[0] = '{reads: 16, wbs: 0, depth: 0, drain: 12};
        rows[1] = '{reads: 16, wbs: 15, depth: 1, drain: 12};
        rows[2] = '{reads: 16, wbs: 8, depth: 2, drain: 12};
        rows[3] = '{reads: 8, wbs: 6, depth: 5, drain: 2};
        apply_reset();
        watch_load();
        for (int i = 0; i < 4; i++) begin
            run_iteration(i);
            run_drain(i);
        end
        watch_done();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
hdl/ntt_ctrl_pkg.sv
hdl/load_timer.sv
hdl/iter_sequencer.sv
hdl/butterfly_counter.sv
hdl/ctrl_decode.sv
hdl/ntt_ctrl_top.sv
dv/ntt_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ntt_ctrl_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --assert --timing -j 0
PASS_MSG  ?= Done: no errors

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard include/*.svh) $(wildcard hdl/*.sv) $(wildcard dv/*.sv) $(FILELIST)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
